// File: source/csr_pkg.sv
// Machine mode only; no interrupts, direct mtvec, ID registers read as zero
package csr_pkg;

  localparam int xlen       = 64;
  localparam int csr_addr_w = 12;

  localparam logic [csr_addr_w-1:0] addr_mstatus   = 12'h300;
  localparam logic [csr_addr_w-1:0] addr_misa      = 12'h301;
  localparam logic [csr_addr_w-1:0] addr_mie       = 12'h304;
  localparam logic [csr_addr_w-1:0] addr_mtvec     = 12'h305;
  localparam logic [csr_addr_w-1:0] addr_mscratch  = 12'h340;
  localparam logic [csr_addr_w-1:0] addr_mepc      = 12'h341;
  localparam logic [csr_addr_w-1:0] addr_mcause    = 12'h342;
  localparam logic [csr_addr_w-1:0] addr_mtval     = 12'h343;
  localparam logic [csr_addr_w-1:0] addr_mip       = 12'h344;
  localparam logic [csr_addr_w-1:0] addr_mcycle    = 12'hb00;
  localparam logic [csr_addr_w-1:0] addr_mvendorid = 12'hf11;
  localparam logic [csr_addr_w-1:0] addr_marchid   = 12'hf12;
  localparam logic [csr_addr_w-1:0] addr_mimpid    = 12'hf13;
  localparam logic [csr_addr_w-1:0] addr_mhartid   = 12'hf14;

  localparam logic [xlen-1:0] mstatus_reset = 64'h1888; // MPP=3, MPIE=1, MIE=1
  localparam logic [xlen-1:0] mie_reset     = 64'h888;
  localparam logic [xlen-1:0] misa_value    = 64'h8000_0000_0000_0100; // RV64, base I

  localparam int mstatus_mie_bit  = 3;
  localparam int mstatus_mpie_bit = 7;
  localparam int mstatus_mpp_lsb  = 11;

  localparam logic [xlen-1:0] cause_illegal = 64'd2;
  localparam logic [xlen-1:0] cause_ecall_m = 64'd11;

  localparam logic [6:0]  opcode_system = 7'h73;
  localparam logic [11:0] funct12_ecall = 12'h000;
  localparam logic [11:0] funct12_mret  = 12'h302;

  typedef enum logic [2:0] {
    op_none,
    op_write,
    op_set,
    op_clear,
    op_ecall,
    op_mret,
    op_illegal
  } csr_op_e;

  typedef struct packed {
    csr_op_e               op;
    logic [csr_addr_w-1:0] csr_addr;
    logic [4:0]            rd;
    logic [xlen-1:0]       operand;  // rs1 value or zero-extended uimm
    logic                  write_en;
    logic [xlen-1:0]       pc;
    logic [31:0]           instr;
  } decoded_t;

  typedef struct packed {
    csr_op_e         op;
    logic [4:0]      rd;
    logic [xlen-1:0] old_value;
    logic [xlen-1:0] pc;
    logic [31:0]     instr;
  } exec_t;

  typedef struct packed {
    logic [xlen-1:0] mstatus;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
  } csr_view_t;

  typedef struct packed {
    logic            enter;  // Trap entry
    logic            leave;  // mret
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    logic [xlen-1:0] mtval;
    logic [xlen-1:0] mstatus;
  } trap_update_t;

  typedef struct packed {
    logic [4:0]      rd;
    logic [xlen-1:0] data;
  } wb_t;

endpackage

// File: source/csr_decode.sv
// Pure combinational; misa and the ID registers are read-only, any write to them traps
`timescale 1ns/100ps

module csr_decode import csr_pkg::*; (
  input  logic [31:0]     instr,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] rs1_value,
  output decoded_t        dec
);

  logic [6:0]  opcode;
  logic [4:0]  rd;
  logic [2:0]  funct3;
  logic [4:0]  rs1;
  logic [11:0] funct12;
  logic        addr_known;
  logic        addr_ro;
  logic        wr_req;

  assign opcode  = instr[6:0];
  assign rd      = instr[11:7];
  assign funct3  = instr[14:12];
  assign rs1     = instr[19:15];
  assign funct12 = instr[31:20];

  // CSRRW always writes, set and clear only with a nonzero source field
  assign wr_req = (funct3[1:0] == 2'b01) || (rs1 != 5'd0);

  always_comb begin
    case (funct12)
      addr_mstatus, addr_misa, addr_mie, addr_mtvec, addr_mscratch,
      addr_mepc, addr_mcause, addr_mtval, addr_mip, addr_mcycle,
      addr_mvendorid, addr_marchid, addr_mimpid, addr_mhartid: addr_known = 1'b1;
      default: addr_known = 1'b0;
    endcase
  end

  always_comb begin
    case (funct12)
      addr_misa, addr_mvendorid, addr_marchid, addr_mimpid, addr_mhartid: addr_ro = 1'b1;
      default: addr_ro = 1'b0;
    endcase
  end

  always_comb begin
    dec.csr_addr = funct12;
    dec.rd       = rd;
    dec.operand  = funct3[2] ? xlen'(rs1) : rs1_value; // Immediate forms use uimm
    dec.write_en = 1'b0;
    dec.pc       = pc;
    dec.instr    = instr;
    dec.op       = op_none;
    if (opcode != opcode_system) begin
      dec.op = op_illegal;
    end else if (funct3 == 3'b000) begin
      case (funct12)
        funct12_ecall: dec.op = op_ecall;
        funct12_mret:  dec.op = op_mret;
        default:       dec.op = op_illegal;
      endcase
    end else begin
      case (funct3[1:0])
        2'b01:   dec.op = op_write;
        2'b10:   dec.op = op_set;
        2'b11:   dec.op = op_clear;
        default: dec.op = op_illegal; // funct3 100 is reserved
      endcase
      dec.write_en = wr_req;
      if (!addr_known || (wr_req && addr_ro)) begin
        dec.op = op_illegal;
      end
    end
  end

endmodule

// File: source/csr_execute.sv
// One instruction per cycle; the file read is combinational and sees all earlier writes
`timescale 1ns/100ps

module csr_execute import csr_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  dec_valid,
  input  decoded_t              dec,
  input  logic [xlen-1:0]       rd_data,
  output logic [csr_addr_w-1:0] rd_addr,
  output logic                  wr_en,
  output logic [csr_addr_w-1:0] wr_addr,
  output logic [xlen-1:0]       wr_data,
  output logic                  ex_valid,
  output exec_t                 ex
);

  decoded_t stage;
  logic     valid;
  logic     is_csr_op;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else begin
      valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      stage <= dec;
    end
  end

  assign is_csr_op = (stage.op == op_write) || (stage.op == op_set) || (stage.op == op_clear);

  assign rd_addr = stage.csr_addr;
  assign wr_addr = stage.csr_addr;
  assign wr_en   = valid && is_csr_op && stage.write_en;

  // Read-modify-write on the current CSR value
  always_comb begin
    case (stage.op)
      op_set:   wr_data = rd_data | stage.operand;
      op_clear: wr_data = rd_data & ~stage.operand;
      default:  wr_data = stage.operand;
    endcase
  end

  assign ex_valid     = valid;
  assign ex.op        = stage.op;
  assign ex.rd        = stage.rd;
  assign ex.old_value = rd_data;  // Goes back to rd
  assign ex.pc        = stage.pc;
  assign ex.instr     = stage.instr;

endmodule

// File: source/csr_file.sv
// mip is plain storage, no interrupt logic; a trap update wins over a CSR write
`timescale 1ns/100ps

module csr_file import csr_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [csr_addr_w-1:0] rd_addr,
  input  logic                  wr_en,
  input  logic [csr_addr_w-1:0] wr_addr,
  input  logic [xlen-1:0]       wr_data,
  input  trap_update_t          trap_upd,
  output logic [xlen-1:0]       rd_data,
  output csr_view_t             view
);

  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] mie;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mscratch;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] mcause;
  logic [xlen-1:0] mtval;
  logic [xlen-1:0] mip;
  logic [xlen-1:0] mcycle;

  // Write strobe for one address
  function automatic logic wr_hit(input logic [csr_addr_w-1:0] addr);
    return wr_en && (wr_addr == addr);
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus  <= mstatus_reset;
      mie      <= mie_reset;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
      mip      <= '0;
    end else begin
      if (trap_upd.enter || trap_upd.leave) begin
        mstatus <= trap_upd.mstatus;
      end else if (wr_hit(addr_mstatus)) begin
        mstatus <= wr_data;
      end

      if (trap_upd.enter) begin  // Trap entry owns mepc, mcause and mtval
        mepc   <= trap_upd.mepc;
        mcause <= trap_upd.mcause;
        mtval  <= trap_upd.mtval;
      end else begin
        if (wr_hit(addr_mepc)) begin
          mepc <= wr_data;
        end
        if (wr_hit(addr_mcause)) begin
          mcause <= wr_data;
        end
        if (wr_hit(addr_mtval)) begin
          mtval <= wr_data;
        end
      end

      if (wr_hit(addr_mie)) begin
        mie <= wr_data;
      end
      if (wr_hit(addr_mtvec)) begin
        mtvec <= wr_data;  // Direct mode only
      end
      if (wr_hit(addr_mscratch)) begin
        mscratch <= wr_data;
      end
      if (wr_hit(addr_mip)) begin
        mip <= wr_data;
      end
    end
  end

  // Free-running cycle counter where a write replaces that cycle's increment
  always_ff @(posedge clk) begin
    if (rst) begin
      mcycle <= '0;
    end else if (wr_hit(addr_mcycle)) begin
      mcycle <= wr_data;
    end else begin
      mcycle <= mcycle + 64'd1;
    end
  end

  always_comb begin
    case (rd_addr)
      addr_mstatus:  rd_data = mstatus;
      addr_misa:     rd_data = misa_value;
      addr_mie:      rd_data = mie;
      addr_mtvec:    rd_data = mtvec;
      addr_mscratch: rd_data = mscratch;
      addr_mepc:     rd_data = mepc;
      addr_mcause:   rd_data = mcause;
      addr_mtval:    rd_data = mtval;
      addr_mip:      rd_data = mip;
      addr_mcycle:   rd_data = mcycle;  // Present value, not the next one
      default:       rd_data = '0;  // ID registers read as zero
    endcase
  end

  assign view.mstatus = mstatus;
  assign view.mtvec   = mtvec;
  assign view.mepc    = mepc;

endmodule

// File: source/csr_commit.sv
// Trap update is combinational in the execute cycle; strobes are registered and last one cycle
`timescale 1ns/100ps

module csr_commit import csr_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            ex_valid,
  input  exec_t           ex,
  input  csr_view_t       view,
  output trap_update_t    trap_upd,
  output logic            wb_valid,
  output wb_t             wb,
  output logic            redirect_valid,
  output logic [xlen-1:0] redirect_pc
);

  logic            is_trap;
  logic            is_ret;
  logic            is_csr_op;
  logic [xlen-1:0] status_next;

  assign is_trap   = ex_valid && ((ex.op == op_ecall) || (ex.op == op_illegal));
  assign is_ret    = ex_valid && (ex.op == op_mret);
  assign is_csr_op = (ex.op == op_write) || (ex.op == op_set) || (ex.op == op_clear);

  always_comb begin
    status_next = view.mstatus;
    if (is_trap) begin
      status_next[mstatus_mpie_bit]        = view.mstatus[mstatus_mie_bit];
      status_next[mstatus_mie_bit]         = 1'b0;
      status_next[mstatus_mpp_lsb +: 2]    = 2'b11;  // Trap taken into M mode
    end else if (is_ret) begin
      status_next[mstatus_mie_bit]  = view.mstatus[mstatus_mpie_bit];
      status_next[mstatus_mpie_bit] = 1'b1;
    end
  end

  assign trap_upd.enter   = is_trap;
  assign trap_upd.leave   = is_ret;
  assign trap_upd.mepc    = ex.pc;
  assign trap_upd.mcause  = (ex.op == op_ecall) ? cause_ecall_m : cause_illegal;
  assign trap_upd.mtval   = (ex.op == op_illegal) ? xlen'(ex.instr) : '0;
  assign trap_upd.mstatus = status_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid       <= 1'b0;
      redirect_valid <= 1'b0;
    end else begin
      wb_valid       <= ex_valid && is_csr_op && (ex.rd != 5'd0);
      redirect_valid <= is_trap || is_ret;
    end
  end

  always_ff @(posedge clk) begin
    wb.rd   <= ex.rd;
    wb.data <= ex.old_value;
    if (is_ret) begin
      redirect_pc <= view.mepc;
    end else begin
      redirect_pc <= {view.mtvec[xlen-1:2], 2'b00};
    end
  end

endmodule

// File: source/csr_top.sv
// Two-cycle latency from instr_valid to wb_valid or redirect_valid; no back-pressure
`timescale 1ns/100ps

module csr_top import csr_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            instr_valid,
  input  logic [31:0]     instr,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] rs1_value,
  output logic            wb_valid,
  output wb_t             wb,
  output logic            redirect_valid,
  output logic [xlen-1:0] redirect_pc
);

  decoded_t              dec;
  exec_t                 ex;
  logic                  ex_valid;
  logic [csr_addr_w-1:0] rd_addr;
  logic [xlen-1:0]       rd_data;
  logic                  wr_en;
  logic [csr_addr_w-1:0] wr_addr;
  logic [xlen-1:0]       wr_data;
  csr_view_t             view;
  trap_update_t          trap_upd;

  csr_decode u_decode (
    .instr     (instr),
    .pc        (pc),
    .rs1_value (rs1_value),
    .dec       (dec)
  );

  csr_execute u_execute (
    .clk       (clk),
    .rst       (rst),
    .dec_valid (instr_valid),
    .dec       (dec),
    .rd_data   (rd_data),
    .rd_addr   (rd_addr),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .ex_valid  (ex_valid),
    .ex        (ex)
  );

  csr_file u_file (
    .clk      (clk),
    .rst      (rst),
    .rd_addr  (rd_addr),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .trap_upd (trap_upd),
    .rd_data  (rd_data),
    .view     (view)
  );

  csr_commit u_commit (
    .clk            (clk),
    .rst            (rst),
    .ex_valid       (ex_valid),
    .ex             (ex),
    .view           (view),
    .trap_upd       (trap_upd),
    .wb_valid       (wb_valid),
    .wb             (wb),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

endmodule

// File: testbench/csr_tb.sv
// Expects the fixed 2-cycle latency; random SYSTEM instructions against an in-order CSR model
`timescale 1ns/100ps

module csr_tb import csr_pkg::*; ();

  typedef struct packed {
    logic            wb_valid;
    wb_t             wb;
    logic            redirect_valid;
    logic [xlen-1:0] redirect_pc;
  } expect_t;

  logic            clk;
  logic            rst;
  logic            instr_valid;
  logic [31:0]     instr;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] rs1_value;
  logic            wb_valid;
  wb_t             wb;
  logic            redirect_valid;
  logic [xlen-1:0] redirect_pc;

  expect_t exp_q[$];  // One entry per cycle, checked two cycles later
  int      cyc;
  int      wb_errs;
  int      redirect_errs;
  int      strobe_errs;

  // Reference CSR state
  logic [xlen-1:0] m_mstatus;
  logic [xlen-1:0] m_mie;
  logic [xlen-1:0] m_mtvec;
  logic [xlen-1:0] m_mscratch;
  logic [xlen-1:0] m_mepc;
  logic [xlen-1:0] m_mcause;
  logic [xlen-1:0] m_mtval;
  logic [xlen-1:0] m_mip;
  logic [xlen-1:0] m_mcycle;     // Counter value right after edge mcycle_edge
  int              mcycle_edge;

  logic [11:0] csr_addrs [14] = '{addr_mstatus, addr_misa, addr_mie, addr_mtvec,
                                  addr_mscratch, addr_mepc, addr_mcause, addr_mtval,
                                  addr_mip, addr_mcycle, addr_mvendorid, addr_marchid,
                                  addr_mimpid, addr_mhartid};

  csr_top uut (
    .clk            (clk),
    .rst            (rst),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .pc             (pc),
    .rs1_value      (rs1_value),
    .wb_valid       (wb_valid),
    .wb             (wb),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic is_known(input logic [11:0] a);
    for (int i = 0; i < 14; i++) begin
      if (csr_addrs[4'(i)] == a) return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic logic is_read_only(input logic [11:0] a);
    return (a == addr_misa) || (a >= 12'hf11 && a <= 12'hf14);
  endfunction

  function automatic logic [xlen-1:0] read_csr(input logic [11:0] a);
    case (a)
      addr_mstatus:  return m_mstatus;
      addr_misa:     return 64'h8000_0000_0000_0100;  // MXL=2 and the I bit
      addr_mie:      return m_mie;
      addr_mtvec:    return m_mtvec;
      addr_mscratch: return m_mscratch;
      addr_mepc:     return m_mepc;
      addr_mcause:   return m_mcause;
      addr_mtval:    return m_mtval;
      addr_mip:      return m_mip;
      addr_mcycle:   return m_mcycle + 64'(cyc + 1 - mcycle_edge);  // Read in the execute cycle
      default:       return '0;
    endcase
  endfunction

  task automatic write_csr(input logic [11:0] a, input logic [xlen-1:0] d);
    case (a)
      addr_mstatus:  m_mstatus = d;
      addr_mie:      m_mie = d;
      addr_mtvec:    m_mtvec = d;
      addr_mscratch: m_mscratch = d;
      addr_mepc:     m_mepc = d;
      addr_mcause:   m_mcause = d;
      addr_mtval:    m_mtval = d;
      addr_mip:      m_mip = d;
      addr_mcycle: begin
        m_mcycle    = d;
        mcycle_edge = cyc + 2;
      end
      default: ;
    endcase
  endtask

  task automatic enter_trap(input logic [xlen-1:0] epc, input logic [xlen-1:0] cause,
                            input logic [xlen-1:0] tval);
    m_mepc         = epc;
    m_mcause       = cause;
    m_mtval        = tval;
    m_mstatus[7]   = m_mstatus[3];  // MPIE <= MIE
    m_mstatus[3]   = 1'b0;
    m_mstatus[12:11] = 2'b11;
  endtask

  // Apply one instruction to the model and return what the outputs must show
  task automatic apply_instr(input logic [31:0] ins, input logic [xlen-1:0] ipc,
                             input logic [xlen-1:0] src, output expect_t e);
    logic [2:0]      f3;
    logic [4:0]      rs1f;
    logic [11:0]     f12;
    logic            sys;
    logic            wen;
    logic [xlen-1:0] opnd;
    logic [xlen-1:0] old;
    logic [xlen-1:0] nxt;
    f3   = ins[14:12];
    rs1f = ins[19:15];
    f12  = ins[31:20];
    sys  = (ins[6:0] == 7'h73);
    wen  = (f3[1:0] == 2'b01) || (rs1f != 5'd0);
    opnd = f3[2] ? {59'd0, rs1f} : src;
    e    = '0;
    if (sys && f3 == 3'b000 && f12 == 12'h302) begin
      e.redirect_valid = 1'b1;
      e.redirect_pc    = m_mepc;
      m_mstatus[3]     = m_mstatus[7];
      m_mstatus[7]     = 1'b1;
    end else if (sys && f3 == 3'b000 && f12 == 12'h000) begin
      e.redirect_valid = 1'b1;
      e.redirect_pc    = {m_mtvec[xlen-1:2], 2'b00};
      enter_trap(ipc, 64'd11, '0);
    end else if (!sys || f3[1:0] == 2'b00 || !is_known(f12) || (wen && is_read_only(f12))) begin
      e.redirect_valid = 1'b1;
      e.redirect_pc    = {m_mtvec[xlen-1:2], 2'b00};
      enter_trap(ipc, 64'd2, {32'd0, ins});
    end else begin
      old = read_csr(f12);
      case (f3[1:0])
        2'b01:   nxt = opnd;
        2'b10:   nxt = old | opnd;
        default: nxt = old & ~opnd;
      endcase
      if (wen) write_csr(f12, nxt);
      e.wb_valid = (ins[11:7] != 5'd0);
      e.wb.rd    = ins[11:7];
      e.wb.data  = old;
    end
  endtask

  task automatic check_wb(input wb_t want, input wb_t got);
    if (got.rd !== want.rd) begin
      wb_errs++;
      $display("ERR wb.rd exp %h got %h at cycle %0d", want.rd, got.rd, cyc);
    end
    if (got.data !== want.data) begin
      wb_errs++;
      $display("ERR wb.data exp %h got %h at cycle %0d", want.data, got.data, cyc);
    end
  endtask

  task automatic check_redirect(input logic [xlen-1:0] want, input logic [xlen-1:0] got);
    if (got !== want) begin
      redirect_errs++;
      $display("ERR redirect_pc exp %h got %h at cycle %0d", want, got, cyc);
    end
  endtask

  task automatic compare_outputs();
    expect_t e;
    e = exp_q.pop_front();
    if (wb_valid !== e.wb_valid) begin
      strobe_errs++;
      $display("%s write-back strobe at cycle %0d", e.wb_valid ? "Missing" : "Unexpected", cyc);
    end else if (e.wb_valid) begin
      check_wb(e.wb, wb);
    end
    if (redirect_valid !== e.redirect_valid) begin
      strobe_errs++;
      $display("%s redirect strobe at cycle %0d", e.redirect_valid ? "Missing" : "Unexpected", cyc);
    end else if (e.redirect_valid) begin
      check_redirect(e.redirect_pc, redirect_pc);
    end
  endtask

  // Each clock checks the outputs and then drives the next input set
  task automatic step(input logic v, input logic [31:0] ins, input logic [xlen-1:0] ipc,
                      input logic [xlen-1:0] src);
    expect_t e;
    @(posedge clk);
    #10;
    cyc++;
    compare_outputs();
    instr_valid = v;
    instr       = ins;
    pc          = ipc;
    rs1_value   = src;
    e = '0;
    if (v) apply_instr(ins, ipc, src, e);
    exp_q.push_back(e);
  endtask

  function automatic logic [31:0] random_instr();
    logic [4:0]  rdf;
    logic [4:0]  rs1f;
    logic [2:0]  f3;
    logic [3:0]  idx;
    int unsigned pick;
    rdf  = 5'($urandom);
    rs1f = ($urandom % 4 == 0) ? 5'd0 : 5'($urandom);
    f3   = 3'($urandom % 3 + 1);
    if ($urandom % 2 == 0) f3[2] = 1'b1;  // Immediate form
    idx  = 4'($urandom % 14);
    pick = $urandom % 100;
    if (pick < 55) return {csr_addrs[idx], rs1f, f3, rdf, 7'h73};
    if (pick < 65) return {12'($urandom), rs1f, f3, rdf, 7'h73};
    if (pick < 75) return 32'h0000_0073;  // ecall
    if (pick < 85) return 32'h3020_0073;  // mret
    if (pick < 89) return {12'($urandom), 13'd0, 7'h73};
    if (pick < 92) return {12'($urandom), rs1f, 3'b100, rdf, 7'h73};
    return {25'($urandom), 7'($urandom % 115)};  // Never the SYSTEM opcode
  endfunction

  function automatic logic results_pending();
    foreach (exp_q[i]) begin
      if (exp_q[i].wb_valid || exp_q[i].redirect_valid) return 1'b1;
    end
    return 1'b0;
  endfunction

  initial begin
    int unsigned     seed_val;
    int              guard;
    logic [xlen-1:0] src;
    expect_t         idle;
    seed_val    = $urandom(73665);
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    rs1_value   = '0;
    cyc         = 0;
    wb_errs     = 0;
    redirect_errs = 0;
    strobe_errs = 0;
    m_mstatus   = 64'h1888;
    m_mie       = 64'h888;
    m_mtvec     = '0;
    m_mscratch  = '0;
    m_mepc      = '0;
    m_mcause    = '0;
    m_mtval     = '0;
    m_mip       = '0;
    m_mcycle    = '0;
    mcycle_edge = 5;
    idle        = '0;
    repeat (5) @(posedge clk);
    #10;
    rst = 1'b0;
    cyc = 5;
    exp_q.push_back(idle);
    exp_q.push_back(idle);

    // Read every CSR back to back with csrrs x1, csr, x0
    for (int i = 0; i < 14; i++) begin
      step(1'b1, {csr_addrs[4'(i)], 5'd0, 3'b010, 5'd1, 7'h73}, 64'h100, 64'hdead);
    end
    // Dependent accesses on mscratch, then a trap and a return
    step(1'b1, {addr_mscratch, 5'd3, 3'b001, 5'd2, 7'h73}, 64'h200, 64'h1234_5678_9abc_def0);
    step(1'b1, {addr_mscratch, 5'd5, 3'b110, 5'd2, 7'h73}, 64'h204, 64'd0);
    step(1'b1, {addr_mscratch, 5'd4, 3'b011, 5'd2, 7'h73}, 64'h208, 64'h0000_0000_ffff_0000);
    step(1'b1, {addr_mtvec, 5'd6, 3'b001, 5'd0, 7'h73}, 64'h20c, 64'h8000_0103);
    step(1'b1, 32'h0000_0073, 64'h210, 64'd0);
    step(1'b1, 32'h3020_0073, 64'h214, 64'd0);

    repeat (400) begin
      if ($urandom % 3 != 0) begin
        repeat ($urandom % 3 + 1) step(1'b0, '0, '0, '0);
      end
      src = {$urandom, $urandom};
      if ($urandom % 4 == 0) src = 64'($urandom % 16);
      step(1'b1, random_instr(), {$urandom, $urandom} & ~64'h3, src);
    end

    guard = 0;
    while (results_pending() && guard < 10) begin
      step(1'b0, '0, '0, '0);
      guard++;
    end
    if (results_pending()) begin
      $display("Timeout: expected results never drained from the pipeline");
    end
    $display("Errors: write-back %0d, redirect %0d, strobe %0d",
             wb_errs, redirect_errs, strobe_errs);
    if (!results_pending() && wb_errs == 0 && redirect_errs == 0 && strobe_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: filelist.f
source/csr_pkg.sv
source/csr_decode.sv
source/csr_execute.sv
source/csr_file.sv
source/csr_commit.sv
source/csr_top.sv
testbench/csr_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run; the log decides pass or fail
rm -f sim.log
verilator --binary --timing -f filelist.f --top-module csr_tb -o csr_sim > build.log 2>&1 &&
./obj_dir/csr_sim > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -qF "*** TEST PASSED ***" sim.log && echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
